//--- verilog.f
+incdir+logic
logic/gfx_pkg.sv
logic/isa_pkg.sv
logic/pixel_if.sv
logic/span_gen.sv
logic/cmd_engine.sv
logic/canvas_agu.sv
logic/colour_lane.sv
logic/vram_pack.sv
logic/earthrise_top.sv
sim/tb_clock.sv
sim/earthrise_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f verilog.f --top-module earthrise_tb -o earthrise_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/earthrise_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim/earthrise_tb.sv
// Directed tests for the graphics engine top level.
// Inputs change on the falling edge; vram writes are taken on the falling edge too.
// Expected images come from the clip, index and packing rules of the engine.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module earthrise_tb;
    import gfx_pkg::*;
    import isa_pkg::*;

    localparam int PERIOD_NS = 100;
    localparam int RST_CYCLES = 16;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 4000;
    localparam int ROM_WORDS = 1 << `ER_CMD_ADDR_W;
    localparam int VRAM_WORDS = 1 << `ER_VRAM_ADDR_W;
    localparam int WATCHDOG_NS = (NUM_TESTS * CYCLES_PER_TEST + RST_CYCLES) * PERIOD_NS;

    logic clk;
    logic rst;
    logic start;
    cord_t canv_w;
    cord_t canv_h;
    bpp_t canv_bpp;
    logic [`ER_WORD-1:0] cmd_list;
    logic [`ER_CMD_ADDR_W+1:0] pc;
    logic [`ER_VRAM_ADDR_W-1:0] addr_base;
    logic [`ER_VRAM_ADDR_W-1:0] vram_addr;
    logic [`ER_WORD-1:0] vram_din;
    logic [`ER_WORD-1:0] vram_wmask;
    logic busy;
    logic eng_done;
    logic instr_invalid;

    logic [`ER_WORD-1:0] rom [ROM_WORDS];
    word_t vram [VRAM_WORDS];
    word_t expected [VRAM_WORDS];
    logic refill = 1'b0;  // vram model reloads its fill pattern
    int writes = 0;
    logic [15:0] prog [$];
    logic [7:0] colr_reg [4] = '{8'd1, 8'd1, 8'd1, 8'd1};  // line a, line b, fill a, fill b
    int txr = 0;
    int tyr = 0;
    logic [31:0] lfsr = 32'h58ce;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clock_gen (
        .clk(clk),
        .rst(rst)
    );

    earthrise_top dut (
        .clk(clk),
        .rst(rst),
        .start(start),
        .canv_w(canv_w),
        .canv_h(canv_h),
        .canv_bpp(canv_bpp),
        .cmd_list(cmd_list),
        .pc(pc),
        .addr_base(addr_base),
        .vram_addr(vram_addr),
        .vram_din(vram_din),
        .vram_wmask(vram_wmask),
        .busy(busy),
        .done(eng_done),
        .instr_invalid(instr_invalid)
    );

    function automatic word_t fill_word(input logic [`ER_VRAM_ADDR_W-1:0] a);
        return word_t'({a, 4'h5, ~a});
    endfunction

    // command ROM, word index is the byte pc over 4
    initial begin
        cmd_list = '0;
        forever begin
            @(negedge clk);
            cmd_list = rom[pc[`ER_CMD_ADDR_W+1:2]];
        end
    end

    always @(negedge clk) begin
        if (refill) begin
            for (int a = 0; a < VRAM_WORDS; a++) begin
                vram[a] <= fill_word(a[`ER_VRAM_ADDR_W-1:0]);
            end
        end else if (vram_wmask != '0) begin
            vram[vram_addr] <= (vram[vram_addr] & ~vram_wmask) | (vram_din & vram_wmask);
            writes <= writes + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST + RST_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_int(input int nbits, output int v);
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(lfsr[0]);  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [15:0] set_ins(input opcode_e op, input int v);
        return {op, v[11:0]};
    endfunction

    function automatic logic [15:0] ctrl_ins(input ctrl_fun_e f, input logic [7:0] imm);
        return {ctrl, f, imm};
    endfunction

    function automatic logic [15:0] draw_ins(input draw_fun_e f, input logic [1:0] opt);
        return {draw, f, 6'd0, opt};
    endfunction

    task automatic emit(input logic [15:0] ins);
        prog.push_back(ins);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic check_image(input string what);
        int bad;
        bad = 0;
        checks++;
        for (int a = 0; a < VRAM_WORDS; a++) begin
            assert (vram[a] === expected[a]) else begin
                bad++;
                if (bad <= 4) begin  // first few only
                    $display("mismatch at %0t ns: %s, vram word %0h is %h, expected %h",
                             $time, what, a, vram[a], expected[a]);
                end
            end
        end
        if (bad != 0) begin
            errors += bad;
            $display("%s: %0d vram words hold the wrong value", what, bad);
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - e0);
        end
    endtask

    task automatic set_canvas(input int w, input int h, input int bpp, input int base);
        @(negedge clk);
        canv_w = cord_t'(w);
        canv_h = cord_t'(h);
        canv_bpp = bpp_t'(bpp);
        addr_base = base[`ER_VRAM_ADDR_W-1:0];
        @(posedge clk);
        refill = 1'b1;
        @(posedge clk);
        refill = 1'b0;
        for (int a = 0; a < VRAM_WORDS; a++) begin
            expected[a] = fill_word(a[`ER_VRAM_ADDR_W-1:0]);
        end
    endtask

    // clip, then word = index / pixels per word, slot = index mod pixels per word
    task automatic expect_pixel(input int x, input int y, input int c);
        int bpp;
        int ppw;
        int idx;
        int slot;
        int a;
        word_t m;
        if (x < 0 || y < 0 || x >= int'(canv_w) || y >= int'(canv_h)) begin
            return;
        end
        case (int'(canv_bpp))
            1, 2, 8: bpp = int'(canv_bpp);
            default: bpp = 4;
        endcase
        ppw = 32 / bpp;
        idx = y * int'(canv_w) + x;
        slot = idx % ppw;
        a = (int'(addr_base) + idx / ppw) % VRAM_WORDS;
        m = word_t'((1 << bpp) - 1) << (slot * bpp);
        expected[a] = (expected[a] & ~m) | ((word_t'(c) << (slot * bpp)) & m);
    endtask

    task automatic expect_span(input int x0, input int x1, input int y, input int c);
        int lo;
        int hi;
        lo = (x0 < x1) ? x0 : x1;
        hi = (x0 < x1) ? x1 : x0;
        for (int x = lo; x <= hi; x++) begin
            expect_pixel(x, y, c);
        end
    endtask

    function automatic int pick_colour(input logic [1:0] opt);
        return int'(colr_reg[{opt[OPT_FILL], opt[OPT_COLR]}]);
    endfunction

    task automatic set_colours(input logic [7:0] la, input logic [7:0] lb,
                               input logic [7:0] fa, input logic [7:0] fb);
        emit(ctrl_ins(line_colr_a, la));
        emit(ctrl_ins(line_colr_b, lb));
        emit(ctrl_ins(fill_colr_a, fa));
        emit(ctrl_ins(fill_colr_b, fb));
        colr_reg = '{la, lb, fa, fb};
    endtask

    task automatic set_translation(input int x, input int y);
        emit(set_ins(trans_x, x));
        emit(set_ins(trans_y, y));
        txr = x;
        tyr = y;
    endtask

    // screen coordinates in, immediates are taken before translation
    task automatic emit_vertices(input int x0, input int y0, input int x1, input int y1);
        emit(set_ins(vx0, x0 - txr));
        emit(set_ins(vy0, y0 - tyr));
        emit(set_ins(vx1, x1 - txr));
        emit(set_ins(vy1, y1 - tyr));
    endtask

    task automatic draw_pixel_at(input int x, input int y, input logic [1:0] opt);
        emit(set_ins(vx0, x - txr));
        emit(set_ins(vy0, y - tyr));
        emit(draw_ins(pixel, opt));
        expect_pixel(x, y, pick_colour(opt));
    endtask

    task automatic draw_span(input int x0, input int x1, input int y, input logic [1:0] opt);
        emit_vertices(x0, y, x1, y);
        emit(draw_ins(hline, opt));
        expect_span(x0, x1, y, pick_colour(opt));
    endtask

    task automatic draw_rect(input int x0, input int y0, input int x1, input int y1,
                             input logic [1:0] opt);
        int lo;
        int hi;
        lo = (y0 < y1) ? y0 : y1;
        hi = (y0 < y1) ? y1 : y0;
        emit_vertices(x0, y0, x1, y1);
        emit(draw_ins(rect, opt));
        for (int y = lo; y <= hi; y++) begin
            expect_span(x0, x1, y, pick_colour(opt));
        end
    endtask

    task automatic random_rect(input logic [1:0] opt);
        int x0;
        int y0;
        int x1;
        int y1;
        random_int(6, x0);
        random_int(4, y0);
        random_int(6, x1);
        random_int(4, y1);
        draw_rect(x0 - 12, y0 - 3, x1 - 12, y1 - 3, opt);  // may reach past every edge
    endtask

    // loads prog plus a closing stop, pulses start, waits for done
    task automatic run_program(output logic inval);
        prog.push_back(ctrl_ins(stop, 8'h00));
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = {2{ctrl_ins(stop, 8'h00)}};
        end
        for (int i = 0; i < prog.size(); i++) begin
            if (i % 2 == 1) begin
                rom[i / 2][31:16] = prog[i];
            end else begin
                rom[i / 2][15:0] = prog[i];
            end
        end
        prog.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("busy after start", busy, 1);
        check_value("instr_invalid after start", instr_invalid, 0);
        while (!eng_done) begin
            @(negedge clk);
        end
        check_value("busy with done", busy, 0);
        inval = instr_invalid;
        @(negedge clk);
        check_value("done one cycle later", eng_done, 0);
        check_value("instr_invalid held after done", instr_invalid, inval);
        repeat (`ER_PIX_LAT) @(negedge clk);  // drain the pixel path
    endtask

    task automatic test_reset_and_stop();
        int e0;
        int w0;
        logic inval;
        e0 = errors;
        check_value("busy after reset", busy, 0);
        check_value("done after reset", eng_done, 0);
        check_value("instr_invalid after reset", instr_invalid, 0);
        check_value("vram_wmask after reset", vram_wmask, 0);
        check_value("pc after reset", pc, 0);
        set_canvas(16, 8, 8, 'h0200);
        w0 = writes;
        run_program(inval);
        check_value("instr_invalid after stop", inval, 0);
        check_value("writes by a stop program", writes - w0, 0);
        check_image("stop program");
        report_test("reset and stop", e0);
    endtask

    task automatic test_pixels();
        int e0;
        logic inval;
        e0 = errors;
        set_canvas(16, 8, 8, 'h0200);
        set_translation(0, 0);
        set_colours(8'h11, 8'h22, 8'h33, 8'h44);
        draw_pixel_at(0, 0, 2'b00);
        draw_pixel_at(1, 0, 2'b01);
        draw_pixel_at(2, 0, 2'b10);
        draw_pixel_at(3, 0, 2'b11);
        draw_pixel_at(6, 3, 2'b01);
        draw_pixel_at(15, 7, 2'b10);
        draw_pixel_at(16, 2, 2'b00);  // right of the canvas
        draw_pixel_at(4, -1, 2'b11);
        draw_pixel_at(-1, 5, 2'b01);  // index is still inside vram
        run_program(inval);
        check_value("instr_invalid after pixels", inval, 0);
        check_image("pixels at 8 bpp");
        report_test("pixels", e0);
    endtask

    task automatic test_hline();
        int e0;
        logic inval;
        e0 = errors;
        set_canvas(24, 6, 4, 'h0400);
        set_translation(5, 2);
        set_colours(8'h11, 8'h5a, 8'h33, 8'h44);
        draw_span(20, 3, 4, 2'b10);
        draw_span(26, 17, 1, 2'b00);  // crosses the right edge
        run_program(inval);
        check_value("instr_invalid after lines", inval, 0);
        check_image("lines at 4 bpp");
        report_test("horizontal line", e0);
    endtask

    task automatic test_rects();
        int e0;
        logic inval;
        e0 = errors;
        set_canvas(40, 10, 2, 'h0800);
        set_translation(0, 0);
        set_colours(8'h01, 8'h02, 8'h07, 8'h0e);
        random_rect(2'b11);
        random_rect(2'b01);
        run_program(inval);
        check_value("instr_invalid after 2 bpp rects", inval, 0);
        check_image("rects at 2 bpp");
        set_canvas(40, 10, 1, 'h0c00);
        random_rect(2'b01);
        random_rect(2'b11);
        run_program(inval);
        check_value("instr_invalid after 1 bpp rects", inval, 0);
        check_image("rects at 1 bpp");
        report_test("filled rectangles", e0);
    endtask

    task automatic test_invalid();
        int e0;
        int w0;
        logic inval;
        e0 = errors;
        set_canvas(16, 8, 8, 'h0200);
        set_translation(0, 0);
        w0 = writes;
        emit(ctrl_ins(nop, 8'h00));
        emit(16'h5123);  // opcode 5 is not in the set
        emit(set_ins(vx0, 1));
        emit(set_ins(vy0, 1));
        emit(draw_ins(pixel, 2'b00));
        run_program(inval);
        check_value("instr_invalid for unknown opcode", inval, 1);
        emit(ctrl_ins(nop, 8'h00));
        emit_vertices(2, 1, 9, 2);
        emit(draw_ins(hline, 2'b00));
        emit(draw_ins(pixel, 2'b00));
        run_program(inval);
        check_value("instr_invalid for sloped line", inval, 1);
        check_value("writes after invalid programs", writes - w0, 0);
        draw_pixel_at(2, 3, 2'b00);
        run_program(inval);
        check_value("instr_invalid for valid program", inval, 0);
        check_image("invalid instructions");
        report_test("invalid instructions", e0);
    endtask

    initial begin
        start = 1'b0;
        canv_w = cord_t'(16);
        canv_h = cord_t'(8);
        canv_bpp = bpp_t'(8);
        addr_base = '0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        test_reset_and_stop();
        test_pixels();
        test_hline();
        test_rects();
        test_invalid();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// Free-running clock and synchronous reset for the testbench.
// Reset is high for RST_CYCLES rising edges and drops on a falling edge.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);  // release away from the sampling edge
        rst = 1'b0;
    end
endmodule

`default_nettype wire

//--- logic/earthrise_top.sv
// Vector graphics engine top. The vram must take one write per cycle,
// and vram outputs follow each plotted pixel by 3 cycles.
// Canvas bpp of 1, 2, 4 or 8; other values act as 4.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module earthrise_top (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire gfx_pkg::cord_t canv_w,
    input  wire gfx_pkg::cord_t canv_h,
    input  wire gfx_pkg::bpp_t canv_bpp,
    input  wire logic [`ER_WORD-1:0] cmd_list,
    output logic [`ER_CMD_ADDR_W+1:0] pc,
    input  wire logic [`ER_VRAM_ADDR_W-1:0] addr_base,
    output logic [`ER_VRAM_ADDR_W-1:0] vram_addr,
    output logic [`ER_WORD-1:0] vram_din,
    output logic [`ER_WORD-1:0] vram_wmask,
    output logic busy,
    output logic done,
    output logic instr_invalid
);
    import gfx_pkg::*;

    pix_id_t pix_id;
    logic clip;
    logic we;
    colr_t field;

    pixel_if pix ();

    cmd_engine engine (
        .clk(clk),
        .rst(rst),
        .start(start),
        .cmd_list(cmd_list),
        .pc(pc),
        .pix(pix),
        .busy(busy),
        .done(done),
        .instr_invalid(instr_invalid)
    );

    canvas_agu agu (
        .clk(clk),
        .rst(rst),
        .canv_w(canv_w),
        .canv_h(canv_h),
        .canv_bpp(canv_bpp),
        .addr_base(addr_base),
        .pix(pix),
        .addr(vram_addr),
        .pix_id(pix_id),
        .clip(clip)
    );

    colour_lane lane (
        .clk(clk),
        .rst(rst),
        .canv_bpp(canv_bpp),
        .pix(pix),
        .we(we),
        .field(field)
    );

    vram_pack pack (
        .canv_bpp(canv_bpp),
        .pix_id(pix_id),
        .clip(clip),
        .we(we),
        .field(field),
        .vram_din(vram_din),
        .vram_wmask(vram_wmask)
    );

endmodule

`default_nettype wire

//--- logic/vram_pack.sv
// Places the colour field and write mask at the pixel slot of the word.
// Purely combinational. bpp outside 1/2/4/8 acts as 4.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module vram_pack (
    input  wire gfx_pkg::bpp_t canv_bpp,
    input  wire gfx_pkg::pix_id_t pix_id,
    input  wire logic clip,
    input  wire logic we,
    input  wire gfx_pkg::colr_t field,
    output gfx_pkg::word_t vram_din,
    output gfx_pkg::word_t vram_wmask
);
    import gfx_pkg::*;

    localparam int SHW = $clog2(`ER_WORD);

    logic [SHW-1:0] sh;  // pix_id * bpp
    word_t ones;  // bpp ones at bit 0

    always_comb begin
        case (canv_bpp)
            5'd1: begin
                ones = word_t'(8'h01);
                sh = SHW'(pix_id);
            end
            5'd2: begin
                ones = word_t'(8'h03);
                sh = SHW'({pix_id, 1'b0});
            end
            5'd8: begin
                ones = word_t'(8'hff);
                sh = SHW'({pix_id, 3'b000});
            end
            default: begin
                ones = word_t'(8'h0f);
                sh = SHW'({pix_id, 2'b00});
            end
        endcase
        vram_din = word_t'(field) << sh;
        vram_wmask = (we && !clip) ? (ones << sh) : '0;
    end

    // field must already be cut to the canvas depth
    always_comb begin
        if (we && !clip) begin
            assert ((vram_din & ~vram_wmask) == '0) else $error("colour field wider than a pixel");
        end
    end

endmodule

`default_nettype wire

//--- logic/colour_lane.sv
// Delays write enable and colour to line up with the address path.
// Colour is cut to the canvas depth, bpp outside 1/2/4/8 acts as 4.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module colour_lane (
    input  wire logic clk,
    input  wire logic rst,
    input  wire gfx_pkg::bpp_t canv_bpp,
    pixel_if.lane pix,
    output logic we,
    output gfx_pkg::colr_t field
);
    import gfx_pkg::*;

    localparam int LAT = `ER_PIX_LAT;

    logic [LAT-1:0] we_sr;
    colr_t colr_d [LAT];
    colr_t depth_mask;

    always_comb begin
        case (canv_bpp)
            5'd1: depth_mask = colr_t'(8'h01);
            5'd2: depth_mask = colr_t'(8'h03);
            5'd8: depth_mask = colr_t'(8'hff);
            default: depth_mask = colr_t'(8'h0f);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            we_sr <= '0;
        end else begin
            we_sr <= {we_sr[LAT-2:0], pix.plot};
        end
    end

    always_ff @(posedge clk) begin
        colr_d[0] <= pix.colr & depth_mask;  // field sits at bit 0
        for (int i = 1; i < LAT; i++) begin
            colr_d[i] <= colr_d[i-1];
        end
    end

    assign we = we_sr[LAT-1];
    assign field = colr_d[LAT-1];

endmodule

`default_nettype wire

//--- logic/canvas_agu.sv
// Clip test and vram address for each plotted pixel, 3 cycles deep.
// bpp other than 1, 2, 4 or 8 is treated as 4. Canvas size must be positive.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module canvas_agu (
    input  wire logic clk,
    input  wire logic rst,
    input  wire gfx_pkg::cord_t canv_w,
    input  wire gfx_pkg::cord_t canv_h,
    input  wire gfx_pkg::bpp_t canv_bpp,
    input  wire logic [`ER_VRAM_ADDR_W-1:0] addr_base,
    pixel_if.agu pix,
    output logic [`ER_VRAM_ADDR_W-1:0] addr,
    output gfx_pkg::pix_id_t pix_id,
    output logic clip
);
    import gfx_pkg::*;

    localparam int IDXW = 2 * $bits(cord_t);

    logic [2:0] shift;  // 5 - log2(bpp)
    pix_id_t pid_mask;
    logic signed [IDXW-1:0] idx1;  // y * w + x
    logic [IDXW-1:0] word2;
    pix_id_t pid2;
    logic clip1, clip2;

    if (`ER_PIX_LAT != 3) begin : g_lat_check
        $error("canvas_agu has a fixed 3-stage pipeline");
    end

    always_comb begin
        case (canv_bpp)
            5'd1: shift = 3'd5;
            5'd2: shift = 3'd4;
            5'd8: shift = 3'd2;
            default: shift = 3'd3;
        endcase
        pid_mask = pix_id_t'((32'd1 << shift) - 32'd1);
    end

    always_ff @(posedge clk) begin
        if (pix.plot) begin
            idx1 <= pix.y * canv_w + pix.x;  // stage 1
        end
        word2 <= idx1 >> shift;  // stage 2
        pid2 <= pix_id_t'(idx1) & pid_mask;
        addr <= addr_base + word2[`ER_VRAM_ADDR_W-1:0];  // stage 3
        pix_id <= pid2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clip1 <= 1'b1;
            clip2 <= 1'b1;
            clip <= 1'b1;
        end else begin
            if (pix.plot) begin
                clip1 <= (pix.x < 0) || (pix.y < 0) || (pix.x >= canv_w) || (pix.y >= canv_h);
            end
            clip2 <= clip1;
            clip <= clip2;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmd_engine.sv
// Fetches two instructions per command word, starting at byte address 0.
// The command ROM must answer one cycle after pc changes.
// busy and done do not cover the 3 cycles of pixel path latency.
`timescale 1ns/1ps
`default_nettype none

`include "er_settings.svh"

module cmd_engine (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire gfx_pkg::word_t cmd_list,
    output logic [`ER_CMD_ADDR_W+1:0] pc,
    pixel_if.engine pix,
    output logic busy,
    output logic done,
    output logic instr_invalid
);
    import gfx_pkg::*;
    import isa_pkg::*;

    localparam int PCW = `ER_CMD_ADDR_W + 3;  // top bit flags overflow
    localparam int IW = $bits(instr_t);

    eng_state_e state;
    logic [PCW-1:0] pc_r;  // byte address of next instruction
    instr_t instr;
    instr_t ir;  // instruction under execution
    cord_t imm12;
    colr_t imm8;
    cord_t tx0, ty0, tx1, ty1;  // translated vertices
    cord_t xt, yt;
    colr_t lca, lcb, fca, fcb;
    cord_t row, row_end;  // current and last span row
    logic span_start, span_valid, span_done;
    cord_t span_x;

    assign pc = pc_r[PCW-2:0];
    assign instr = pc_r[1] ? cmd_list[2*IW-1:IW] : cmd_list[IW-1:0];
    assign imm12 = cord_t'({ir.fun, ir.hi, ir.lo});
    assign imm8 = {ir.hi, ir.lo};
    assign span_start = (state == span_init);
    assign busy = (state != idle) && (state != isa_pkg::done);
    assign done = (state == isa_pkg::done);

    always_ff @(posedge clk) begin
        pix.plot <= 1'b0;
        case (state)
            fetch: state <= decode;  // rom word valid next cycle
            decode: begin
                if (pc_r[PCW-1]) begin
                    state <= isa_pkg::done;  // ran off the end of the list
                end else begin
                    ir <= instr;
                    pc_r <= pc_r + PCW'(2);
                    state <= exec;
                end
            end
            exec: begin
                state <= fetch;
                case (opcode_e'(ir.opcode))
                    vx0: tx0 <= imm12 + xt;
                    vy0: ty0 <= imm12 + yt;
                    vx1: tx1 <= imm12 + xt;
                    vy1: ty1 <= imm12 + yt;
                    trans_x: xt <= imm12;
                    trans_y: yt <= imm12;
                    ctrl: begin
                        case (ctrl_fun_e'(ir.fun))
                            line_colr_a: lca <= imm8;
                            line_colr_b: lcb <= imm8;
                            fill_colr_a: fca <= imm8;
                            fill_colr_b: fcb <= imm8;
                            nop: state <= fetch;
                            stop: state <= isa_pkg::done;
                            default: begin
                                state <= isa_pkg::done;
                                instr_invalid <= 1'b1;
                            end
                        endcase
                    end
                    draw: begin
                        pix.colr <= imm8[OPT_FILL] ? (imm8[OPT_COLR] ? fcb : fca)
                                                   : (imm8[OPT_COLR] ? lcb : lca);
                        case (draw_fun_e'(ir.fun))
                            pixel: begin
                                pix.plot <= 1'b1;
                                pix.x <= tx0;
                                pix.y <= ty0;
                            end
                            hline: begin
                                if (ty0 == ty1) begin
                                    row <= ty0;
                                    row_end <= ty0;
                                    state <= span_init;
                                end else begin
                                    state <= isa_pkg::done;  // sloped lines not supported
                                    instr_invalid <= 1'b1;
                                end
                            end
                            rect: begin
                                row <= (ty0 < ty1) ? ty0 : ty1;
                                row_end <= (ty0 < ty1) ? ty1 : ty0;
                                state <= span_init;
                            end
                            default: begin
                                state <= isa_pkg::done;
                                instr_invalid <= 1'b1;
                            end
                        endcase
                    end
                    default: begin
                        state <= isa_pkg::done;
                        instr_invalid <= 1'b1;
                    end
                endcase
            end
            span_init: state <= span_run;  // span_gen latches x0 and x1
            span_run: begin
                pix.plot <= span_valid;
                pix.x <= span_x;
                pix.y <= row;
                if (span_done) begin
                    if (row == row_end) begin
                        state <= fetch;
                    end else begin
                        row <= row + cord_t'(1);
                        state <= span_init;
                    end
                end
            end
            isa_pkg::done: begin
                state <= idle;
                pc_r <= '0;  // every run starts at address 0
            end
            default: begin
                if (start) begin
                    state <= fetch;
                    instr_invalid <= 1'b0;
                end
            end
        endcase
        if (rst) begin
            state <= idle;
            pc_r <= '0;
            pix.plot <= 1'b0;
            instr_invalid <= 1'b0;
            lca <= colr_t'(1);  // nonzero so a bare draw is visible
            lcb <= colr_t'(1);
            fca <= colr_t'(1);
            fcb <= colr_t'(1);
            xt <= '0;
            yt <= '0;
        end
    end

    span_gen span (
        .clk(clk),
        .rst(rst),
        .start(span_start),
        .x0(tx0),
        .x1(tx1),
        .x(span_x),
        .valid(span_valid),
        .done(span_done)
    );

    // every cycle of a running span must carry a column
    assert property (@(posedge clk) disable iff (rst) (state == span_run) |-> span_valid)
        else $error("span generator stopped in the middle of a span");

endmodule

`default_nettype wire

//--- logic/span_gen.sv
// Walks x from x0 to x1 inclusive, either direction, one column per cycle.
// start must not be pulsed while a span is still running.
`timescale 1ns/1ps
`default_nettype none

module span_gen (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire gfx_pkg::cord_t x0,
    input  wire gfx_pkg::cord_t x1,
    output gfx_pkg::cord_t x,
    output logic valid,
    output logic done
);
    import gfx_pkg::*;

    cord_t x_end;  // latched end column
    logic step_dn;  // walking toward smaller x
    logic run;

    assign valid = run;
    assign done = run && (x == x_end);  // with the last column

    always_ff @(posedge clk) begin
        if (start) begin
            x <= x0;
            x_end <= x1;
            step_dn <= (x1 < x0);
        end else if (run) begin
            x <= step_dn ? x - cord_t'(1) : x + cord_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (start) begin
            run <= 1'b1;
        end else if (done) begin
            run <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !run)
        else $error("span start while a span is running");

endmodule

`default_nettype wire

//--- logic/pixel_if.sv
// One plotted pixel per cycle while plot is high. No handshake,
// the consumers must take every pixel.
`timescale 1ns/1ps
`default_nettype none

interface pixel_if;
    import gfx_pkg::*;

    logic  plot;  // write strobe
    cord_t x;
    cord_t y;
    colr_t colr;

    modport engine (output plot, x, y, colr);
    modport agu (input plot, x, y);
    modport lane (input plot, colr);
endinterface

`default_nettype wire

//--- logic/isa_pkg.sv
// Instruction set of the command list. Instructions are 16 bits,
// two per word, lower half first.
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        vx0     = 4'h0,
        vy0     = 4'h1,
        vy1     = 4'h2,
        vx1     = 4'h3,
        trans_x = 4'h8,
        trans_y = 4'h9,
        ctrl    = 4'hc,
        draw    = 4'hd
    } opcode_e;

    typedef enum logic [3:0] {
        line_colr_a = 4'h0,
        line_colr_b = 4'h1,
        fill_colr_a = 4'h2,
        fill_colr_b = 4'h3,
        nop         = 4'hc,
        stop        = 4'he
    } ctrl_fun_e;

    typedef enum logic [3:0] {
        pixel = 4'h0,
        hline = 4'h1,  // y0 must equal y1
        rect  = 4'h4   // always filled
    } draw_fun_e;

    typedef enum logic [3:0] {
        idle, fetch, decode, exec, span_init, span_run, done
    } eng_state_e;

    localparam int OPT_FILL = 0;  // fill colour instead of line colour
    localparam int OPT_COLR = 1;  // colour B instead of A

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] fun;
        logic [3:0] hi;
        logic [3:0] lo;
    } instr_t;

endpackage

`default_nettype wire

//--- logic/gfx_pkg.sv
// Pixel, colour and vram word types shared by the draw path.
// Coordinates are signed integers with no fraction bits.
`default_nettype none

`include "er_settings.svh"

package gfx_pkg;

    typedef logic signed [`ER_CORD_W-1:0] cord_t;  // screen coordinate
    typedef logic [`ER_COLR_W-1:0] colr_t;
    typedef logic [4:0] bpp_t;  // only 1, 2, 4 and 8 are real depths
    typedef logic [`ER_WORD-1:0] word_t;
    typedef logic [$clog2(`ER_WORD)-1:0] pix_id_t;  // pixel slot inside a word

endpackage

`default_nettype wire

//--- logic/er_settings.svh
// Build-time sizes for the graphics engine.
// The pixel path is built for a latency of exactly 3 cycles.
`ifndef ER_SETTINGS_SVH
`define ER_SETTINGS_SVH

`define ER_WORD 32         // machine and vram word
`define ER_CORD_W 12       // signed integer coordinate
`define ER_COLR_W 8        // colour register width
`define ER_CMD_ADDR_W 10   // command list word address
`define ER_VRAM_ADDR_W 14  // vram word address
`define ER_PIX_LAT 3       // pixel to vram write latency

`endif
